// File: Bender.yml
package:
  name: ppu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/ppu_pkg.sv
      - hw/ppu_apb_regs.sv
      - hw/raster_timing.sv
      - hw/bg_tile_fetch.sv
      - hw/sprite_select.sv
      - hw/pixel_compose.sv
      - hw/ppu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/ppu_assertions.sv
      - tb/ppu_tb.sv

// File: build.f
+incdir+include
hw/ppu_pkg.sv
hw/ppu_apb_regs.sv
hw/raster_timing.sv
hw/bg_tile_fetch.sv
hw/sprite_select.sv
hw/pixel_compose.sv
hw/ppu_top.sv
tb/ppu_assertions.sv
tb/ppu_tb.sv

// File: hw/bg_tile_fetch.sv
`include "ppu_defs.svh"

module bg_tile_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ppu_pkg::raster_pos_t pos_in,
    input  ppu_pkg::nt_wr_t      nt_wr,
    output ppu_pkg::bg_stage_t   bg_out
);

    logic [3:0] name_tbl [`PPU_NT_SIZE];
    logic [9:0] rd_addr;

    // tile index = row/8 * 32 + col/8, only meaningful inside the window
    always_comb begin
        rd_addr = 10'd0;
        if (pos_in.visible) begin
            rd_addr = {pos_in.row[7:3], pos_in.col[7:3]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PPU_NT_SIZE; i++) begin
                name_tbl[i] <= 4'h0;
            end
            bg_out <= '0;
        end else begin
            if (nt_wr.en) begin
                name_tbl[nt_wr.addr] <= nt_wr.data;
            end
            bg_out.pos    <= pos_in;
            bg_out.bg_idx <= name_tbl[rd_addr];   // old data on a same-edge write
        end
    end

endmodule

// File: hw/pixel_compose.sv
`include "ppu_defs.svh"

module pixel_compose (
    input  logic                clk,
    input  logic                rst_n,
    input  ppu_pkg::sp_stage_t  sp_in,
    input  ppu_pkg::pal_wr_t    pal_wr,
    input  logic [4:0]          pal_rd_addr,
    output logic [5:0]          pal_rd_data,
    output ppu_pkg::pixel_out_t pix
);

    logic [5:0] palette [`PPU_PAL_SIZE];
    logic       sp_opaque;
    logic       bg_opaque;
    logic       sp_wins;
    logic [4:0] pal_addr;

    assign sp_opaque = sp_in.sp_idx[1:0] != 2'b00;
    assign bg_opaque = sp_in.bg.bg_idx[1:0] != 2'b00;
    // sprite loses only when it is behind and the background shows
    assign sp_wins   = sp_opaque && !(bg_opaque && sp_in.sp_prio);
    assign pal_addr  = sp_wins ? {1'b1, sp_in.sp_idx} : {1'b0, sp_in.bg.bg_idx};

    assign pal_rd_data = palette[pal_rd_addr];  // cpu side

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PPU_PAL_SIZE; i++) begin
                palette[i] <= 6'h00;
            end
            pix <= '0;
        end else begin
            if (pal_wr.en) begin
                palette[pal_wr.addr] <= pal_wr.data;
            end
            pix.row   <= sp_in.bg.pos.row;
            pix.col   <= sp_in.bg.pos.col;
            pix.color <= palette[pal_addr];
            pix.valid <= sp_in.bg.pos.visible;
        end
    end

endmodule

// File: hw/ppu_apb_regs.sv
`include "ppu_defs.svh"

module ppu_apb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [13:0]        paddr,
    input  logic [31:0]        pwdata,
    input  logic               vblank,
    input  logic               visible,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output ppu_pkg::nt_wr_t    nt_wr,
    output ppu_pkg::sp_wr_t    sp_wr,
    output ppu_pkg::pal_wr_t   pal_wr,
    output logic [4:0]         pal_rd_addr,
    input  logic [5:0]         pal_rd_data
);

    logic [11:0] idx;       // word index
    logic [11:0] sp_off;
    logic [11:0] pal_off;
    logic        nt_hit;
    logic        sp_hit;
    logic        pal_hit;
    logic        stat_hit;
    logic        dec_err;
    logic        wr_acc;

    assign idx     = paddr[13:2];
    assign sp_off  = idx - 12'(`PPU_SP_BASE);
    assign pal_off = idx - 12'(`PPU_PAL_BASE);

    // address map decode
    assign nt_hit   = idx < 12'(`PPU_NT_BASE + `PPU_NT_SIZE);
    assign sp_hit   = (idx >= 12'(`PPU_SP_BASE)) &&
                      (idx < 12'(`PPU_SP_BASE + `PPU_NUM_SPRITES));
    assign pal_hit  = (idx >= 12'(`PPU_PAL_BASE)) &&
                      (idx < 12'(`PPU_PAL_BASE + `PPU_PAL_SIZE));
    assign stat_hit = idx == 12'(`PPU_STATUS_IDX);
    assign dec_err  = !(nt_hit || sp_hit || pal_hit || stat_hit);

    // writes land in the access phase
    assign wr_acc = psel && penable && pwrite;

    always_comb begin
        nt_wr      = '0;
        nt_wr.en   = wr_acc && nt_hit;
        nt_wr.addr = 10'(idx - 12'(`PPU_NT_BASE));
        nt_wr.data = pwdata[3:0];

        sp_wr      = '0;
        sp_wr.en   = wr_acc && sp_hit;
        sp_wr.idx  = sp_off[2:0];
        sp_wr.data = ppu_pkg::sprite_t'(pwdata[$bits(ppu_pkg::sprite_t)-1:0]);

        pal_wr      = '0;
        pal_wr.en   = wr_acc && pal_hit;
        pal_wr.addr = pal_off[4:0];
        pal_wr.data = pwdata[5:0];
    end

    assign pal_rd_addr = pal_off[4:0];

    // nt and sprite words are write only, read as zero
    always_comb begin
        prdata = 32'h0;
        if (psel && !pwrite) begin
            if (pal_hit) begin
                prdata = {26'h0, pal_rd_data};
            end else if (stat_hit) begin
                prdata = {30'h0, visible, vblank};
            end
        end
    end

    assign pready = 1'b1;   // zero wait states

    // flagged in setup so it shows up exactly in the access cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= psel && !penable && dec_err;
        end
    end

endmodule

// File: hw/ppu_pkg.sv
package ppu_pkg;

    // raster position carried down the pipeline
    typedef struct packed {
        logic [8:0] row;
        logic [8:0] col;
        logic       visible;
    } raster_pos_t;

    typedef struct packed {
        raster_pos_t pos;
        logic [3:0]  bg_idx;
    } bg_stage_t;

    typedef struct packed {
        bg_stage_t  bg;
        logic [3:0] sp_idx;
        logic       sp_prio;    // 1 = behind background
    } sp_stage_t;

    // one sprite, sits in the low bits of an apb word
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic [3:0] color_idx;
        logic       prio;
        logic       enabled;
    } sprite_t;

    typedef struct packed {
        logic       en;
        logic [9:0] addr;
        logic [3:0] data;
    } nt_wr_t;

    typedef struct packed {
        logic       en;
        logic [2:0] idx;
        sprite_t    data;
    } sp_wr_t;

    typedef struct packed {
        logic       en;
        logic [4:0] addr;
        logic [5:0] data;
    } pal_wr_t;

    typedef struct packed {
        logic [8:0] row;
        logic [8:0] col;
        logic [5:0] color;
        logic       valid;
    } pixel_out_t;

endpackage

// File: hw/ppu_top.sv
module ppu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [13:0]         paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                vblank,
    output ppu_pkg::pixel_out_t pix
);

    ppu_pkg::nt_wr_t      nt_wr;
    ppu_pkg::sp_wr_t      sp_wr;
    ppu_pkg::pal_wr_t     pal_wr;
    logic [4:0]           pal_rd_addr;
    logic [5:0]           pal_rd_data;
    logic                 visible;
    ppu_pkg::raster_pos_t pos;      // stage 1
    ppu_pkg::bg_stage_t   bg_st;    // stage 2
    ppu_pkg::sp_stage_t   sp_st;    // stage 3

    ppu_apb_regs u_apb (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .vblank, .visible,
        .prdata, .pready, .pslverr,
        .nt_wr, .sp_wr, .pal_wr,
        .pal_rd_addr, .pal_rd_data
    );

    raster_timing u_raster (
        .clk, .rst_n,
        .pos, .vblank, .visible
    );

    bg_tile_fetch u_bg (
        .clk, .rst_n,
        .pos_in(pos), .nt_wr,
        .bg_out(bg_st)
    );

    sprite_select u_sp (
        .clk, .rst_n,
        .bg_in(bg_st), .sp_wr,
        .sp_out(sp_st)
    );

    pixel_compose u_comp (
        .clk, .rst_n,
        .sp_in(sp_st), .pal_wr,
        .pal_rd_addr, .pal_rd_data,
        .pix
    );

endmodule

// File: hw/raster_timing.sv
`include "ppu_defs.svh"

module raster_timing (
    input  logic                 clk,
    input  logic                 rst_n,
    output ppu_pkg::raster_pos_t pos,
    output logic                 vblank,
    output logic                 visible
);

    logic [8:0] row;
    logic [8:0] col;
    logic       line_end;

    assign line_end = col == 9'(`PPU_LINE_CYCLES - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= 9'd0;
            col <= 9'd0;
        end else begin
            col <= line_end ? 9'd0 : col + 9'd1;
            if (line_end) begin
                row <= (row == 9'(`PPU_FRAME_LINES - 1)) ? 9'd0 : row + 9'd1;
            end
        end
    end

    // set entering vblank row, cleared on the last cycle of the frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank <= 1'b0;
        end else if (row == 9'(`PPU_VBLANK_ROW) && col == 9'd0) begin
            vblank <= 1'b1;
        end else if (row == 9'(`PPU_FRAME_LINES - 1) && line_end) begin
            vblank <= 1'b0;
        end
    end

    assign visible = (row < 9'(`PPU_VIS_H)) && (col < 9'(`PPU_VIS_W));

    assign pos = '{row: row, col: col, visible: visible};

endmodule

// File: hw/sprite_select.sv
`include "ppu_defs.svh"

module sprite_select (
    input  logic               clk,
    input  logic               rst_n,
    input  ppu_pkg::bg_stage_t bg_in,
    input  ppu_pkg::sp_wr_t    sp_wr,
    output ppu_pkg::sp_stage_t sp_out
);

    ppu_pkg::sprite_t             sprites [`PPU_NUM_SPRITES];
    logic [`PPU_NUM_SPRITES-1:0] hit;
    logic [3:0]                  hit_idx;
    logic                        hit_prio;

    // box test, 9 bit sums so x/y near 255 still clip
    always_comb begin
        for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
            hit[i] = sprites[i].enabled &&
                     ({1'b0, sprites[i].x} <= bg_in.pos.col) &&
                     (bg_in.pos.col < {1'b0, sprites[i].x} + 9'd8) &&
                     ({1'b0, sprites[i].y} <= bg_in.pos.row) &&
                     (bg_in.pos.row < {1'b0, sprites[i].y} + 9'd8);
        end
    end

    // walk down so the lowest index wins
    always_comb begin
        hit_idx  = 4'h0;
        hit_prio = 1'b0;
        for (int i = `PPU_NUM_SPRITES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx  = sprites[i].color_idx;
                hit_prio = sprites[i].prio;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
                sprites[i] <= '0;   // all disabled
            end
            sp_out <= '0;
        end else begin
            if (sp_wr.en) begin
                sprites[sp_wr.idx] <= sp_wr.data;
            end
            sp_out.bg      <= bg_in;
            sp_out.sp_idx  <= hit_idx;
            sp_out.sp_prio <= hit_prio;
        end
    end

endmodule

// File: include/ppu_defs.svh
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// raster geometry
`define PPU_LINE_CYCLES 341
`define PPU_FRAME_LINES 262
`define PPU_VIS_W       256
`define PPU_VIS_H       240
`define PPU_VBLANK_ROW  241     // vblank starts here, ends after last line

// table sizes
`define PPU_NT_SIZE     960     // 32 x 30 tiles
`define PPU_NUM_SPRITES 8
`define PPU_PAL_SIZE    32

// apb word index map (byte address >> 2)
`define PPU_NT_BASE     0
`define PPU_SP_BASE     1024
`define PPU_PAL_BASE    1056
`define PPU_STATUS_IDX  1088

`endif

// File: tb/ppu_assertions.sv
module ppu_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                psel,
    input logic                penable,
    input logic                pready,
    input logic                pslverr,
    input logic                vblank,
    input ppu_pkg::pixel_out_t pix
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fails = 0;

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable |-> pready)
        else begin
            fails++;
            $error("pready low in apb access phase");
        end

    // error response only in the access cycle
    a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
        !(psel && penable) |-> !pslverr)
        else begin
            fails++;
            $error("pslverr high outside apb access phase");
        end

    a_window: assert property (@(posedge clk) disable iff (!rst_n)
        pix.valid |-> (pix.row < 9'd240) && (pix.col < 9'd256))
        else begin
            fails++;
            $error("valid pixel outside the 256x240 window");
        end

    a_vblank: assert property (@(posedge clk) disable iff (!rst_n)
        !(vblank && pix.valid))
        else begin
            fails++;
            $error("valid pixel during vblank");
        end

endmodule

bind ppu_top ppu_assertions u_asrt (
    .clk, .rst_n, .psel, .penable, .pready, .pslverr, .vblank, .pix
);

// File: tb/ppu_tb.sv
`include "ppu_defs.svh"

module ppu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SCEN    = 5;
    localparam int FRAME_CYC   = `PPU_LINE_CYCLES * `PPU_FRAME_LINES;
    localparam int TIMEOUT_CYC = NUM_SCEN * FRAME_CYC * 2 + 2000;
    localparam int GAP_IDX     = 970;       // between name table and sprites
    localparam int PAST_SP_IDX = `PPU_SP_BASE + `PPU_NUM_SPRITES;
    localparam int FAR_IDX     = 1100;

    logic                clk;
    logic                rst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [13:0]         paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic                vblank;
    ppu_pkg::pixel_out_t pix;

    ppu_pkg::sprite_t scen_tbl [NUM_SCEN][`PPU_NUM_SPRITES];
    ppu_pkg::sprite_t sp_model [`PPU_NUM_SPRITES];
    logic [3:0]       nt_model [`PPU_NT_SIZE];
    logic [5:0]       pal_model [`PPU_PAL_SIZE];
    int               pix_errs = 0;
    int               rdata_errs = 0;
    int               flag_errs = 0;
    int               other_errs = 0;
    int               cycles = 0;
    int               total;

    ppu_top uut (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .vblank, .pix
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Checks failed");
        $finish;
    end

    task automatic check_pixel(input ppu_pkg::pixel_out_t got, input ppu_pkg::pixel_out_t exp);
        string got_s;
        string exp_s;
        if (got !== exp) begin
            pix_errs++;
            got_s = $sformatf("row %h col %h color %h valid %h",
                              got.row, got.col, got.color, got.valid);
            exp_s = $sformatf("row %h col %h color %h valid %h",
                              exp.row, exp.col, exp.color, exp.valid);
            $display("CHECK FAILED pix: got %s, exp %s", got_s, exp_s);
        end
    endtask

    task automatic check_rdata(input int idx, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            rdata_errs++;
            $display("CHECK FAILED prdata (word %0d): got %h exp %h", idx, got, exp);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("CHECK FAILED %s: got %h exp %h", name, got, exp);
        end
    endtask

    // one zero wait state apb transfer sampled mid access phase
    task automatic apb_xfer(input bit write, input int idx, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = 14'(idx * 4);
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_err("pready", pready, 1'b1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input int idx, input logic [31:0] data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, idx, data, rd, err);
        check_err("pslverr", err, exp_err);
    endtask

    task automatic apb_read(input int idx, input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, idx, 32'h0, rd, err);
        check_rdata(idx, rd, exp_data);
        check_err("pslverr", err, exp_err);
    endtask

    function automatic ppu_pkg::sprite_t make_sprite(int x, int y, int ci, bit prio, bit en);
        return '{x: 8'(x), y: 8'(y), color_idx: 4'(ci), prio: prio, enabled: en};
    endfunction

    task automatic load_scenarios();
        foreach (scen_tbl[s, i]) scen_tbl[s][i] = '0;
        // scenario 0 keeps every sprite disabled
        scen_tbl[1][0] = make_sprite(16, 16, 'h5, 0, 1);
        scen_tbl[1][1] = make_sprite(20, 20, 'h6, 0, 1);    // overlaps sprite 0
        scen_tbl[1][2] = make_sprite(18, 18, 'h7, 0, 0);
        scen_tbl[1][3] = make_sprite(18, 12, 'hb, 0, 1);
        scen_tbl[2][0] = make_sprite(40, 40, 'h3, 1, 1);    // behind bg
        scen_tbl[2][1] = make_sprite(44, 44, 'h9, 1, 1);
        scen_tbl[2][2] = make_sprite(100, 60, 'he, 0, 1);
        scen_tbl[3][0] = make_sprite(250, 236, 'h7, 0, 1);  // clipped right and bottom
        scen_tbl[3][1] = make_sprite(252, 100, 'h2, 0, 1);
        scen_tbl[3][2] = make_sprite(0, 236, 'ha, 1, 1);
        scen_tbl[4][0] = make_sprite(64, 64, 'h4, 0, 1);    // transparent and hides sprite 1
        scen_tbl[4][1] = make_sprite(64, 64, 'h5, 0, 1);
        scen_tbl[4][2] = make_sprite(120, 8, 'h8, 1, 1);
        scen_tbl[4][5] = make_sprite(124, 8, 'hd, 0, 1);
    endtask

    // reference colour for a visible pixel
    function automatic logic [5:0] model_color(int row, int col);
        logic [3:0] bg;
        logic [3:0] sp;
        logic       behind;
        bit         found;
        bit         sp_wins;
        bg     = nt_model[(row / 8) * 32 + col / 8];
        sp     = 4'h0;
        behind = 1'b0;
        found  = 1'b0;
        for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
            if (!found && sp_model[i].enabled &&
                col >= int'(sp_model[i].x) && col < int'(sp_model[i].x) + 8 &&
                row >= int'(sp_model[i].y) && row < int'(sp_model[i].y) + 8) begin
                found  = 1'b1;
                sp     = sp_model[i].color_idx;
                behind = sp_model[i].prio;
            end
        end
        sp_wins = (sp[1:0] != 2'b00) && !((bg[1:0] != 2'b00) && behind);
        return sp_wins ? pal_model[{1'b1, sp}] : pal_model[{1'b0, bg}];
    endfunction

    task automatic load_tables(input int s);
        for (int a = 0; a < `PPU_NT_SIZE; a++) begin
            nt_model[a] = 4'($urandom);
            apb_write(`PPU_NT_BASE + a, {28'h0, nt_model[a]}, 1'b0);
        end
        for (int a = 0; a < `PPU_PAL_SIZE; a++) begin
            pal_model[a] = 6'($urandom);
            apb_write(`PPU_PAL_BASE + a, {26'h0, pal_model[a]}, 1'b0);
        end
        for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
            sp_model[i] = scen_tbl[s][i];
            apb_write(`PPU_SP_BASE + i, 32'(sp_model[i]), 1'b0);
        end
    endtask

    task automatic check_access_rules();
        apb_read(`PPU_NT_BASE + 7, 32'h0, 1'b0);
        apb_read(`PPU_SP_BASE + 2, 32'h0, 1'b0);
        for (int a = 0; a < `PPU_PAL_SIZE; a++) begin
            apb_read(`PPU_PAL_BASE + a, {26'h0, pal_model[a]}, 1'b0);
        end
        // unmapped words leave every table as it was for the next frame
        apb_write(GAP_IDX, 32'hf, 1'b1);
        apb_write(PAST_SP_IDX, 32'(make_sprite(0, 0, 'hf, 0, 1)), 1'b1);
        apb_write(FAR_IDX, 32'h3f, 1'b1);
        apb_read(FAR_IDX, 32'h0, 1'b1);
        apb_read(`PPU_STATUS_IDX, 32'h1, 1'b0);
    endtask

    task automatic wait_valid(input int r, input int c);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pix.valid && n < 200);
        if (!pix.valid) begin
            other_errs++;
            $display("no valid pixel arrived for row %0d col %0d", r, c);
        end
    endtask

    task automatic observe_frame();
        ppu_pkg::pixel_out_t exp;
        do @(negedge clk); while (vblank !== 1'b0);
        for (int r = 0; r < `PPU_VIS_H; r++) begin
            for (int c = 0; c < `PPU_VIS_W; c++) begin
                wait_valid(r, c);
                exp = '{row: 9'(r), col: 9'(c), color: model_color(r, c), valid: 1'b1};
                check_pixel(pix, exp);
            end
        end
        // nothing valid after the last visible row until vblank
        do begin
            @(negedge clk);
            if (pix.valid) begin
                other_errs++;
                $display("extra valid pixel after the last visible row");
            end
        end while (vblank !== 1'b1);
        apb_read(`PPU_STATUS_IDX, 32'h1, 1'b0);
    endtask

    initial begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h4bd7_0907));
        load_scenarios();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_pixel(pix, '0);
        check_err("vblank", vblank, 1'b0);
        check_err("pslverr", pslverr, 1'b0);
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int a = 0; a < `PPU_PAL_SIZE; a++) begin
            apb_read(`PPU_PAL_BASE + a, 32'h0, 1'b0);
        end

        for (int s = 0; s < NUM_SCEN; s++) begin
            do @(negedge clk); while (vblank !== 1'b1);
            load_tables(s);
            check_access_rules();
            observe_frame();
        end

        total = pix_errs + rdata_errs + flag_errs + other_errs + int'(uut.u_asrt.fails);
        $display("errors: pix %0d, prdata %0d, flags %0d, other %0d, assertions %0d",
                 pix_errs, rdata_errs, flag_errs, other_errs, uut.u_asrt.fails);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
